//--- ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Datapath widths
`define EX_DATA_W 32
`define EX_REG_W 5

// Result queue entries
`define EX_FIFO_DEPTH 4

// Credits granted by the writeback stage after reset
`define EX_WB_CREDITS 2

// Fault number of a divide by zero
`define EX_FAULT_DIVZERO 7'h0D

`endif

//--- ex_pkg.sv
`default_nettype none
`include "ex_settings.svh"

package ex_pkg;

	typedef enum logic [2:0] {
		EX_UNIT_LOGIC = 3'd0,
		EX_UNIT_SHIFT = 3'd1,
		EX_UNIT_ADD = 3'd2,
		EX_UNIT_MUL = 3'd3,
		EX_UNIT_DIV = 3'd4
	} ex_unit_e;

	// Operation within the selected unit
	typedef logic [2:0] ex_op_t;

	localparam ex_op_t EX_OP_AND = 3'd0;
	localparam ex_op_t EX_OP_OR = 3'd1;
	localparam ex_op_t EX_OP_XOR = 3'd2;
	localparam ex_op_t EX_OP_NOT = 3'd3;

	localparam ex_op_t EX_OP_SLL = 3'd0;
	localparam ex_op_t EX_OP_SRL = 3'd1;
	localparam ex_op_t EX_OP_SRA = 3'd2;
	localparam ex_op_t EX_OP_ROL = 3'd3;

	localparam ex_op_t EX_OP_ADD = 3'd0;
	localparam ex_op_t EX_OP_SUB = 3'd1;

	localparam ex_op_t EX_OP_MULL = 3'd0;
	localparam ex_op_t EX_OP_MULH = 3'd1;

	localparam ex_op_t EX_OP_UDIV = 3'd0;
	localparam ex_op_t EX_OP_SDIV = 3'd1;
	localparam ex_op_t EX_OP_UMOD = 3'd2;
	localparam ex_op_t EX_OP_SMOD = 3'd3;

	// Queue occupancy from empty to full
	localparam int EX_COUNT_W = $clog2(`EX_FIFO_DEPTH + 1);

	typedef struct packed {
		logic sf;
		logic of;
		logic cf;
		logic pf;
		logic zf;
	} ex_flags_t;

	typedef struct packed {
		logic [`EX_DATA_W-1:0] data;
		logic [`EX_REG_W-1:0] dest;
		logic writeback;
		ex_flags_t flags;
		logic fault;
		logic [6:0] fault_num;
		logic div_sign;
		logic spare;
	} ex_result_t;

endpackage

`default_nettype wire

//--- ex_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_alu import ex_pkg::*; (
	input wire ex_unit_e unit,
	input wire ex_op_t op,
	input wire [`EX_DATA_W-1:0] src0,
	input wire [`EX_DATA_W-1:0] src1,
	output logic [`EX_DATA_W-1:0] data,
	output ex_flags_t flags
);

	localparam int W = `EX_DATA_W;
	localparam int SH_W = $clog2(W);

	logic [SH_W-1:0] shamt;
	logic [W:0] sll_ext;
	logic [W:0] srl_ext;
	logic [W:0] sra_ext;
	logic [W-1:0] rol_res;
	logic [W:0] add_ext;
	logic [W:0] sub_ext;
	logic add_of;
	logic sub_of;
	logic [2*W-1:0] product;
	logic cf;
	logic of;

	assign shamt = src1[SH_W-1:0];

	// Extra bit catches the last bit shifted out
	assign sll_ext = {1'b0, src0} << shamt;
	assign srl_ext = {src0, 1'b0} >> shamt;
	assign sra_ext = $signed({src0, 1'b0}) >>> shamt;
	assign rol_res = (src0 << shamt) | (src0 >> (W - shamt));

	assign add_ext = {1'b0, src0} + {1'b0, src1};
	assign sub_ext = {1'b0, src0} - {1'b0, src1};
	assign add_of = (src0[W-1] == src1[W-1]) && (add_ext[W-1] != src0[W-1]);
	assign sub_of = (src0[W-1] != src1[W-1]) && (sub_ext[W-1] != src0[W-1]);

	assign product = src0 * src1;

	always_comb begin
		data = '0;
		cf = 1'b0;
		of = 1'b0;
		case (unit)
			EX_UNIT_LOGIC: begin
				case (op)
					EX_OP_AND: data = src0 & src1;
					EX_OP_OR: data = src0 | src1;
					EX_OP_XOR: data = src0 ^ src1;
					default: data = ~src0;
				endcase
			end
			EX_UNIT_SHIFT: begin
				case (op)
					EX_OP_SLL: begin
						data = sll_ext[W-1:0];
						cf = sll_ext[W];
					end
					EX_OP_SRL: begin
						data = srl_ext[W:1];
						cf = srl_ext[0];
					end
					EX_OP_SRA: begin
						data = sra_ext[W:1];
						cf = sra_ext[0];
					end
					default: begin
						data = rol_res;
						// Wrapped bit lands in bit 0
						cf = (shamt != '0) && rol_res[0];
					end
				endcase
			end
			EX_UNIT_ADD: begin
				if (op == EX_OP_SUB) begin
					data = sub_ext[W-1:0];
					cf = sub_ext[W];
					of = sub_of;
				end else begin
					data = add_ext[W-1:0];
					cf = add_ext[W];
					of = add_of;
				end
			end
			EX_UNIT_MUL: begin
				if (op == EX_OP_MULH) begin
					data = product[2*W-1:W];
				end else begin
					data = product[W-1:0];
					cf = product[W];
					of = product[W-1] ^ product[W];
				end
			end
			default: data = '0;
		endcase

		flags.sf = data[W-1];
		flags.of = of;
		flags.cf = cf;
		flags.pf = data[0];
		flags.zf = (data == '0);
		// High word looks at the full product
		if (unit == EX_UNIT_MUL && op == EX_OP_MULH) begin
			flags.zf = (product == '0);
		end
	end

endmodule

`default_nettype wire

//--- ex_divider.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_divider (
	input wire iCLOCK,
	input wire inRESET,
	input wire start,
	input wire is_signed,
	input wire [`EX_DATA_W-1:0] dividend,
	input wire [`EX_DATA_W-1:0] divisor,
	output logic done,
	output logic [`EX_DATA_W-1:0] quotient,
	output logic [`EX_DATA_W-1:0] remainder
);

	localparam int W = `EX_DATA_W;
	localparam int IT_W = $clog2(W);

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_LOAD,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	div_state_e state;
	logic [IT_W-1:0] iter;
	logic sgn;
	logic neg_quot;
	logic neg_rem;
	logic [W-1:0] dvd;
	logic [W-1:0] dvs;
	logic [W-1:0] quot;
	logic [W-1:0] rem;
	logic [W:0] rem_shift;
	logic [W+1:0] trial;

	// One restoring step
	assign rem_shift = {rem, quot[W-1]};
	assign trial = {1'b0, rem_shift} - {2'b00, dvs};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= DIV_IDLE;
			iter <= '0;
			sgn <= 1'b0;
			neg_quot <= 1'b0;
			neg_rem <= 1'b0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (start) begin
						state <= DIV_LOAD;
						sgn <= is_signed;
					end
				end
				DIV_LOAD: begin
					state <= DIV_RUN;
					iter <= '0;
					neg_quot <= sgn && (dvd[W-1] ^ dvs[W-1]);
					neg_rem <= sgn && dvd[W-1];
				end
				DIV_RUN: begin
					iter <= iter + 1'b1;
					if (iter == IT_W'(W - 1)) begin
						state <= DIV_DONE;
					end
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		case (state)
			DIV_IDLE: begin
				if (start) begin
					dvd <= dividend;
					dvs <= divisor;
				end
			end
			DIV_LOAD: begin
				// Work on magnitudes
				quot <= (sgn && dvd[W-1]) ? -dvd : dvd;
				dvs <= (sgn && dvs[W-1]) ? -dvs : dvs;
				rem <= '0;
			end
			DIV_RUN: begin
				if (!trial[W+1]) begin
					rem <= trial[W-1:0];
					quot <= {quot[W-2:0], 1'b1};
				end else begin
					rem <= rem_shift[W-1:0];
					quot <= {quot[W-2:0], 1'b0};
				end
			end
			default: ;
		endcase
	end

	assign done = (state == DIV_DONE);
	assign quotient = neg_quot ? -quot : quot;
	assign remainder = neg_rem ? -rem : rem;

	// Issue must hold off while a division is in flight
	a_no_restart: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		start |-> state == DIV_IDLE);

endmodule

`default_nettype wire

//--- ex_issue.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_issue import ex_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire in_valid,
	input wire ex_unit_e in_unit,
	input wire ex_op_t in_op,
	input wire [`EX_DATA_W-1:0] in_src0,
	input wire [`EX_DATA_W-1:0] in_src1,
	input wire [`EX_REG_W-1:0] in_src0_ptr,
	input wire [`EX_REG_W-1:0] in_src1_ptr,
	input wire in_src1_imm,
	input wire [`EX_REG_W-1:0] in_dest,
	input wire in_writeback,
	input wire in_flags_writeback,
	input wire [EX_COUNT_W-1:0] fifo_count,
	output logic busy,
	output logic push,
	output ex_result_t push_data
);

	localparam int W = `EX_DATA_W;

	logic accept;
	logic is_div;
	logic div_signed;
	logic div_zero;
	logic div_start;
	logic div_done;
	logic div_wait;
	logic flags_update;
	logic [W-1:0] src0;
	logic [W-1:0] src1;
	logic [W-1:0] alu_data;
	logic [W-1:0] quotient;
	logic [W-1:0] remainder;
	ex_flags_t alu_flags;
	ex_flags_t flags_reg;
	ex_flags_t flags_next;
	logic last_fwd;
	logic [W-1:0] last_data;
	logic [`EX_REG_W-1:0] last_dest;
	logic [`EX_REG_W-1:0] div_dest;
	logic div_writeback;
	logic div_rem_sel;

	assign busy = div_wait || (fifo_count == EX_COUNT_W'(`EX_FIFO_DEPTH));
	assign accept = in_valid && !busy;
	assign is_div = (in_unit == EX_UNIT_DIV);

	// Bypass from the last pushed record
	assign src0 = (last_fwd && in_src0_ptr == last_dest) ? last_data : in_src0;
	assign src1 = (!in_src1_imm && last_fwd && in_src1_ptr == last_dest) ? last_data : in_src1;

	assign div_signed = (in_op == EX_OP_SDIV) || (in_op == EX_OP_SMOD);
	assign div_zero = accept && is_div && (src1 == '0);
	assign div_start = accept && is_div && (src1 != '0);

	assign flags_update = accept && in_flags_writeback &&
		(in_unit == EX_UNIT_SHIFT || in_unit == EX_UNIT_ADD || in_unit == EX_UNIT_MUL);
	assign flags_next = flags_update ? alu_flags : flags_reg;

	// Divides push on done, everything else on accept
	assign push = (accept && !div_start) || div_done;

	always_comb begin
		push_data = '0;
		push_data.flags = flags_next;
		if (div_done) begin
			push_data.data = div_rem_sel ? remainder : quotient;
			push_data.dest = div_dest;
			push_data.writeback = div_writeback;
		end else if (div_zero) begin
			push_data.dest = in_dest;
			push_data.fault = 1'b1;
			push_data.fault_num = `EX_FAULT_DIVZERO;
		end else begin
			push_data.data = alu_data;
			push_data.dest = in_dest;
			push_data.writeback = in_writeback;
		end
	end

	ex_alu u_alu (
		.unit(in_unit),
		.op(in_op),
		.src0(src0),
		.src1(src1),
		.data(alu_data),
		.flags(alu_flags)
	);

	ex_divider u_divider (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.start(div_start),
		.is_signed(div_signed),
		.dividend(src0),
		.divisor(src1),
		.done(div_done),
		.quotient(quotient),
		.remainder(remainder)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			div_wait <= 1'b0;
			flags_reg <= '0;
			last_fwd <= 1'b0;
		end else begin
			flags_reg <= flags_next;
			if (div_start) begin
				div_wait <= 1'b1;
			end else if (div_done) begin
				div_wait <= 1'b0;
			end
			// Faulted records never feed a source
			if (push) begin
				last_fwd <= push_data.writeback && !push_data.fault;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			last_data <= push_data.data;
			last_dest <= push_data.dest;
		end
		if (div_start) begin
			div_dest <= in_dest;
			div_writeback <= in_writeback;
			div_rem_sel <= (in_op == EX_OP_UMOD) || (in_op == EX_OP_SMOD);
		end
	end

endmodule

`default_nettype wire

//--- ex_result_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_result_fifo import ex_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire push,
	input wire ex_result_t push_data,
	input wire pop,
	output ex_result_t head,
	output logic empty,
	output logic [EX_COUNT_W-1:0] count
);

	localparam int DEPTH = `EX_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	ex_result_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign head = mem[rd_ptr];
	assign empty = (count == '0);

	// Busy from issue and credit gating must keep these
	a_no_overflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		push |-> count < EX_COUNT_W'(DEPTH));
	a_no_underflow: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		pop |-> !empty);

endmodule

`default_nettype wire

//--- ex_writeback_port.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_writeback_port import ex_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire empty,
	input wire ex_result_t head,
	input wire wb_credit,
	output logic pop,
	output logic wb_valid,
	output ex_result_t wb_result
);

	localparam int CRD_W = $clog2(`EX_WB_CREDITS + 1);

	logic [CRD_W-1:0] credits;

	assign pop = !empty && (credits != '0);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			credits <= CRD_W'(`EX_WB_CREDITS);
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= pop;
			// A pulse spends one, a returned credit adds one
			credits <= credits - CRD_W'(pop) + CRD_W'(wb_credit);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (pop) begin
			wb_result <= head;
		end
	end

	// Writeback stage returns no more than it was granted
	a_credit_limit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		credits <= CRD_W'(`EX_WB_CREDITS));

endmodule

`default_nettype wire

//--- ex_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_top import ex_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire in_valid,
	input wire ex_unit_e in_unit,
	input wire ex_op_t in_op,
	input wire [`EX_DATA_W-1:0] in_src0,
	input wire [`EX_DATA_W-1:0] in_src1,
	input wire [`EX_REG_W-1:0] in_src0_ptr,
	input wire [`EX_REG_W-1:0] in_src1_ptr,
	input wire in_src1_imm,
	input wire [`EX_REG_W-1:0] in_dest,
	input wire in_writeback,
	input wire in_flags_writeback,
	output wire busy,
	input wire wb_credit,
	output wire wb_valid,
	output wire ex_result_t wb_result
);

	wire push;
	wire pop;
	wire empty;
	wire ex_result_t push_data;
	wire ex_result_t head;
	wire [EX_COUNT_W-1:0] fifo_count;

	ex_issue u_issue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(in_valid),
		.in_unit(in_unit),
		.in_op(in_op),
		.in_src0(in_src0),
		.in_src1(in_src1),
		.in_src0_ptr(in_src0_ptr),
		.in_src1_ptr(in_src1_ptr),
		.in_src1_imm(in_src1_imm),
		.in_dest(in_dest),
		.in_writeback(in_writeback),
		.in_flags_writeback(in_flags_writeback),
		.fifo_count(fifo_count),
		.busy(busy),
		.push(push),
		.push_data(push_data)
	);

	ex_result_fifo u_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.head(head),
		.empty(empty),
		.count(fifo_count)
	);

	ex_writeback_port u_wb_port (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.empty(empty),
		.head(head),
		.wb_credit(wb_credit),
		.pop(pop),
		.wb_valid(wb_valid),
		.wb_result(wb_result)
	);

endmodule

`default_nettype wire

//--- ex_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module ex_checker import ex_pkg::*; (
	input wire iCLOCK,
	input wire inRESET,
	input wire in_valid,
	input wire busy,
	input wire wb_valid,
	input wire ex_result_t wb_result,
	input wire wb_credit,
	output logic finished,
	output int error_count
);

	localparam int FIELDS = 17;
	localparam int MAX_LINES = 64;
	// Accept to push of a running divide
	localparam int DIV_CYCLES = 34;

	logic [31:0] trace_mem [0:FIELDS*MAX_LINES-1];
	int n_lines;
	int rec_idx;
	int outstanding;
	int cur_test;
	int test_recs;
	int test_errs;
	int line_id;
	ex_result_t expected;
	int queued;
	int accepts;
	int cycle;
	int div_push_at;
	logic div_pending;
	logic busy_expected;

	function automatic ex_result_t build_expected(input int line);
		ex_result_t r;
		int base;
		base = line * FIELDS;
		r = '0;
		r.data = trace_mem[base + 11];
		r.dest = trace_mem[base + 12][`EX_REG_W-1:0];
		r.writeback = trace_mem[base + 13][0];
		r.flags = trace_mem[base + 14][4:0];
		r.fault = trace_mem[base + 15][0];
		r.fault_num = trace_mem[base + 16][6:0];
		return r;
	endfunction

	// A divide with a nonzero divisor holds issue until its push
	function automatic logic divider_runs(input int line);
		int base;
		base = line * FIELDS;
		return trace_mem[base + 1] == 32'(EX_UNIT_DIV) && trace_mem[base + 15] == 32'd0;
	endfunction

	task automatic report_test();
		$display("test %0d done: %0d records, %0d errors", cur_test, test_recs, test_errs);
		test_recs = 0;
		test_errs = 0;
	endtask

	initial begin
		finished = 1'b0;
		error_count = 0;
		rec_idx = 0;
		outstanding = 0;
		cur_test = 0;
		test_recs = 0;
		test_errs = 0;
		queued = 0;
		accepts = 0;
		cycle = 0;
		div_push_at = 0;
		div_pending = 1'b0;
		busy_expected = 1'b0;
		$readmemh("ex_trace.txt", trace_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && trace_mem[n_lines*FIELDS] != 32'hFF) begin
			n_lines++;
		end
	end

	always @(posedge iCLOCK) begin
		if (inRESET) begin
			cycle++;
			// A record on the port left the queue one edge earlier
			if (wb_valid) begin
				queued--;
			end
			busy_expected = div_pending || queued == `EX_FIFO_DEPTH;
			if (busy !== busy_expected) begin
				$display("ERROR at %0t ns: busy expected %0b got %0b",
					$time, busy_expected, busy);
				error_count++;
			end
			if (div_pending && cycle == div_push_at) begin
				div_pending = 1'b0;
				queued++;
			end
			if (in_valid && !busy) begin
				if (accepts < n_lines && divider_runs(accepts)) begin
					div_pending = 1'b1;
					div_push_at = cycle + DIV_CYCLES;
				end else begin
					queued++;
				end
				accepts++;
			end
			outstanding = outstanding + int'(wb_valid) - int'(wb_credit);
			if (outstanding > `EX_WB_CREDITS) begin
				$display("More writeback records in flight than credits granted at %0t ns", $time);
				error_count++;
			end
			if (wb_valid) begin
				if (rec_idx >= n_lines) begin
					$display("An extra writeback record appeared at %0t ns", $time);
					error_count++;
				end else begin
					expected = build_expected(rec_idx);
					line_id = int'(trace_mem[rec_idx*FIELDS]);
					if (rec_idx > 0 && line_id != cur_test) begin
						report_test();
					end
					cur_test = line_id;
					test_recs++;
					if (wb_result !== expected) begin
						$display("ERROR at %0t ns: test %0d record %0d expected %h got %h",
							$time, cur_test, rec_idx, expected, wb_result);
						error_count++;
						test_errs++;
					end
					rec_idx++;
					if (rec_idx == n_lines) begin
						report_test();
						$display("checked %0d of %0d records, %0d errors",
							rec_idx, n_lines, error_count);
						finished = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_ex_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "ex_settings.svh"

module tb_ex_top import ex_pkg::*; ;

	localparam int FIELDS = 17;
	localparam int MAX_LINES = 64;
	localparam int PERIOD = 40;

	logic iCLOCK;
	logic inRESET;
	logic in_valid;
	ex_unit_e in_unit;
	ex_op_t in_op;
	logic [`EX_DATA_W-1:0] in_src0;
	logic [`EX_DATA_W-1:0] in_src1;
	logic [`EX_REG_W-1:0] in_src0_ptr;
	logic [`EX_REG_W-1:0] in_src1_ptr;
	logic in_src1_imm;
	logic [`EX_REG_W-1:0] in_dest;
	logic in_writeback;
	logic in_flags_writeback;
	logic wb_credit;
	wire busy;
	wire wb_valid;
	ex_result_t wb_result;
	logic finished;
	int error_count;

	logic [31:0] trace_mem [0:FIELDS*MAX_LINES-1];
	int n_lines;
	logic withhold;
	logic [15:0] lfsr;
	longint cycle;
	longint due [$];

	ex_top UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(in_valid),
		.in_unit(in_unit),
		.in_op(in_op),
		.in_src0(in_src0),
		.in_src1(in_src1),
		.in_src0_ptr(in_src0_ptr),
		.in_src1_ptr(in_src1_ptr),
		.in_src1_imm(in_src1_imm),
		.in_dest(in_dest),
		.in_writeback(in_writeback),
		.in_flags_writeback(in_flags_writeback),
		.busy(busy),
		.wb_credit(wb_credit),
		.wb_valid(wb_valid),
		.wb_result(wb_result)
	);

	ex_checker u_checker (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.in_valid(in_valid),
		.busy(busy),
		.wb_valid(wb_valid),
		.wb_result(wb_result),
		.wb_credit(wb_credit),
		.finished(finished),
		.error_count(error_count)
	);

	// Galois form with taps at 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_delay(output int d);
		d = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			d = (d << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic drive_line(input int line);
		int base;
		base = line * FIELDS;
		// Long credit delays in the back-pressure test
		withhold = (trace_mem[base] == 32'h05);
		in_unit = ex_unit_e'(trace_mem[base + 1][2:0]);
		in_op = trace_mem[base + 2][2:0];
		in_src0 = trace_mem[base + 3];
		in_src1 = trace_mem[base + 4];
		in_src0_ptr = trace_mem[base + 5][`EX_REG_W-1:0];
		in_src1_ptr = trace_mem[base + 6][`EX_REG_W-1:0];
		in_src1_imm = trace_mem[base + 7][0];
		in_dest = trace_mem[base + 8][`EX_REG_W-1:0];
		in_writeback = trace_mem[base + 9][0];
		in_flags_writeback = trace_mem[base + 10][0];
		in_valid = 1'b1;
		while (busy) begin
			@(posedge iCLOCK);
			#2;
		end
		@(posedge iCLOCK);
		#2;
		in_valid = 1'b0;
	endtask

	initial begin
		iCLOCK = 1'b0;
		forever #(PERIOD/2) iCLOCK = ~iCLOCK;
	end

	initial begin
		$readmemh("ex_trace.txt", trace_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && trace_mem[n_lines*FIELDS] != 32'hFF) begin
			n_lines++;
		end
	end

	// Credits return one pulse per cycle at most
	initial begin
		int d;
		wb_credit = 1'b0;
		lfsr = 16'd3070;
		cycle = 0;
		forever begin
			@(posedge iCLOCK);
			cycle++;
			#2;
			if (inRESET && wb_valid) begin
				random_delay(d);
				if (withhold) begin
					d = d + 24;
				end
				due.push_back(cycle + 1 + longint'(d));
			end
			wb_credit = 1'b0;
			for (int i = 0; i < due.size(); i++) begin
				if (due[i] <= cycle) begin
					wb_credit = 1'b1;
					due.delete(i);
					break;
				end
			end
		end
	end

	initial begin
		inRESET = 1'b0;
		in_valid = 1'b0;
		in_unit = EX_UNIT_LOGIC;
		in_op = '0;
		in_src0 = '0;
		in_src1 = '0;
		in_src0_ptr = '0;
		in_src1_ptr = '0;
		in_src1_imm = 1'b0;
		in_dest = '0;
		in_writeback = 1'b0;
		in_flags_writeback = 1'b0;
		withhold = 1'b0;
		repeat (3) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		@(posedge iCLOCK);
		#2;
		for (int i = 0; i < n_lines; i++) begin
			drive_line(i);
		end
		withhold = 1'b0;
		wait (finished);
		// Leave time for any stray record to show up
		repeat (20) @(posedge iCLOCK);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		#1;
		#(longint'(n_lines) * 40 * PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", n_lines * 40);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_trace.txt
// id unit op src0 src1 src0_ptr src1_ptr imm dest wb flags_wb
// then expected: data dest wb flags(sf,of,cf,pf,zf) fault fault_num; id FF ends the trace
01 0 0 F0F0F0F0 0FF00FF0 1E 1F 0 01 1 1 00F000F0 01 1 00 0 00
01 0 1 12340000 00005678 1E 1F 0 02 1 1 12345678 02 1 00 0 00
01 0 2 FFFF0000 FF00FF00 1E 1F 0 03 1 1 00FFFF00 03 1 00 0 00
01 0 3 0000FFFF 00000000 1E 1F 0 04 1 1 FFFF0000 04 1 00 0 00
01 1 0 80000001 00000001 1E 1F 1 05 1 1 00000002 05 1 04 0 00
01 1 1 00000003 00000001 1E 1F 1 06 1 1 00000001 06 1 06 0 00
01 1 2 80000010 00000004 1E 1F 1 07 1 1 F8000001 07 1 12 0 00
01 1 3 80000001 00000004 1E 1F 1 08 1 1 00000018 08 1 00 0 00
01 2 0 7FFFFFFF 00000001 1E 1F 0 09 1 1 80000000 09 1 18 0 00
01 2 0 FFFFFFFF 00000001 1E 1F 0 0A 1 1 00000000 0A 1 05 0 00
01 2 1 00000005 00000007 1E 1F 0 0B 1 1 FFFFFFFE 0B 1 14 0 00
01 3 0 00010000 00018000 1E 1F 0 0C 1 1 80000000 0C 1 14 0 00
01 3 1 00010000 00018000 1E 1F 0 0D 1 1 00000001 0D 1 02 0 00
01 3 1 00000010 00000010 1E 1F 0 0E 1 1 00000000 0E 1 00 0 00
01 3 1 FFFFFFFF FFFFFFFF 1E 1F 0 0F 1 1 FFFFFFFE 0F 1 10 0 00
02 2 0 00000100 00000023 1E 1F 0 05 1 0 00000123 05 1 10 0 00
02 2 0 00000000 00000001 05 1F 0 06 1 0 00000124 06 1 10 0 00
02 2 0 00001000 00000010 1E 06 1 07 1 0 00001010 07 1 10 0 00
02 0 1 0F000000 00000000 1E 07 0 08 1 0 0F001010 08 1 10 0 00
03 4 0 00000064 00000007 1E 1F 0 09 1 0 0000000E 09 1 10 0 00
03 4 1 FFFFFF9C 00000007 1E 1F 0 0A 1 0 FFFFFFF2 0A 1 10 0 00
03 4 3 FFFFFF9C 00000007 1E 1F 0 0B 1 0 FFFFFFFE 0B 1 10 0 00
03 4 2 00000064 00000007 1E 1F 0 0C 1 0 00000002 0C 1 10 0 00
03 4 3 00000064 FFFFFFF9 1E 1F 0 0D 1 0 00000002 0D 1 10 0 00
03 0 2 00000000 00000003 0D 1F 0 0E 1 0 00000001 0E 1 10 0 00
04 4 0 00000005 00000000 1E 1F 0 0F 1 0 00000000 0F 0 10 1 0D
04 2 0 00000040 00000001 0F 1F 0 10 1 0 00000041 10 1 10 0 00
05 0 0 00000001 FFFFFFFF 1E 1F 0 11 1 0 00000001 11 1 10 0 00
05 0 0 00000002 FFFFFFFF 1E 1F 0 12 1 0 00000002 12 1 10 0 00
05 0 0 00000003 FFFFFFFF 1E 1F 0 13 1 0 00000003 13 1 10 0 00
05 0 0 00000004 FFFFFFFF 1E 1F 0 14 1 0 00000004 14 1 10 0 00
05 0 0 00000005 FFFFFFFF 1E 1F 0 15 1 0 00000005 15 1 10 0 00
05 0 0 00000006 FFFFFFFF 1E 1F 0 16 1 0 00000006 16 1 10 0 00
06 2 1 00000003 00000003 1E 1F 0 17 1 1 00000000 17 1 01 0 00
06 2 0 00000001 00000001 1E 1F 0 18 1 0 00000002 18 1 01 0 00
06 1 0 00000001 00000000 1E 1F 1 19 1 0 00000001 19 1 01 0 00
06 3 0 00000003 00000003 1E 1F 0 1A 1 0 00000009 1A 1 01 0 00
FF 0 0 00000000 00000000 00 00 0 00 0 0 00000000 00 0 00 0 00

//--- sources.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_divider.sv
ex_issue.sv
ex_result_fifo.sv
ex_writeback_port.sv
ex_top.sv
ex_checker.sv
tb_ex_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_ex_top -f sources.f

output=$(./obj_dir/Vtb_ex_top)
echo "$output"

if echo "$output" | grep -q "Regression passed"; then
	exit 0
fi
exit 1
